// File: include/frontend_macros.svh
// fetch front end widths and table sizes
// target buffer geometry, predictor history lengths, boot address

`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// fetch address and block
`define FE_IP_W          43
`define FE_BLOCK_BYTES   16
`define FE_BLK_OFF_W     4

// global history
`define FE_GHT_W         14

// target buffer sets indexed by ip[9:4] with the tag above
`define FE_TB_SETS       64
`define FE_TB_TAG_LO     10

// history bits mixed into each predictor table index
`define FE_PA_BITS       2
`define FE_PB_BITS       8
`define FE_PC_BITS       14
`define FE_PT_IDX_W      8

// return stack
`define FE_RAS_DEPTH     16

`define FE_RESET_IP      43'h100

`endif

// File: verilog/frontend_pkg.sv
// shared types of the fetch front end
// branch kinds, target buffer entry and hit, retire update, fetch output

`include "frontend_macros.svh"

package frontend_pkg;

  typedef logic [`FE_IP_W-1:0]  ip_t;
  typedef logic [`FE_GHT_W-1:0] ght_t;

  typedef enum logic [1:0] {
    BR_COND = 2'd0,
    BR_JUMP = 2'd1,
    BR_CALL = 2'd2,
    BR_RET  = 2'd3
  } branch_kind_e;

  typedef struct packed {
    logic                              valid;
    logic [`FE_IP_W-1:`FE_TB_TAG_LO]   tag;
    branch_kind_e                      kind;
    ip_t                               target;
  } tb_entry_t;

  // one way of a lookup
  typedef struct packed {
    logic         hit;
    branch_kind_e kind;
    ip_t          target;
  } tb_hit_t;

  typedef struct packed {
    logic         valid;
    logic         way;
    branch_kind_e kind;
    ip_t          src_ip;     // block address of the branch
    ip_t          target;
    logic         taken;
    ght_t         ght;        // history seen when the block was fetched
    logic         mispredict;
  } retire_upd_t;

  typedef struct packed {
    logic valid;
    ip_t  ip;
    ght_t ght;
    logic taken;
    logic way;
  } fetch_out_t;

endpackage

// File: verilog/fetch_pointer.sv
// fetch address, global history and valid flag
// per-way taken resolution and next address selection
// return stack push and pop strobes

`timescale 1ns/1ps
`include "frontend_macros.svh"

module fetch_pointer import frontend_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  retire_upd_t   upd,
  input  tb_hit_t [1:0] hits,
  input  logic    [1:0] pred_taken,
  input  ip_t           top_addr,
  output ip_t           ip,
  output ght_t          ght,
  output logic          push,
  output logic          pop,
  output ip_t           push_addr,
  output fetch_out_t    fetch
);

  ip_t        ip_q;
  ght_t       ght_q;
  logic       valid_q;
  logic [1:0] way_taken;
  logic       any_taken;
  logic       sel_way;
  logic       cond_seen;
  logic       redirect;
  tb_hit_t    sel_hit;
  ip_t        taken_ip;
  ip_t        seq_ip;

  assign redirect = upd.valid && upd.mispredict;

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      way_taken[w] = hits[w].hit && (hits[w].kind != BR_COND || pred_taken[w]);
    end
  end

  assign any_taken = |way_taken;
  assign sel_way   = !way_taken[0]; // way 0 first
  assign sel_hit   = hits[sel_way];
  assign cond_seen = (hits[0].hit && hits[0].kind == BR_COND) ||
                     (hits[1].hit && hits[1].kind == BR_COND);

  assign seq_ip   = ip_q + ip_t'(`FE_BLOCK_BYTES);
  assign taken_ip = (sel_hit.kind == BR_RET) ? top_addr : sel_hit.target;

  // stack strobes only for a block that really advances
  assign push      = valid_q && !redirect && any_taken && sel_hit.kind == BR_CALL;
  assign pop       = valid_q && !redirect && any_taken && sel_hit.kind == BR_RET;
  assign push_addr = seq_ip;

  always_ff @(posedge clk) begin
    if (rst) begin
      ip_q    <= `FE_RESET_IP;
      ght_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
      if (redirect) begin
        ip_q  <= upd.src_ip; // replay the branch block
        ght_q <= upd.ght;
      end else if (!valid_q) begin
        ip_q  <= ip_q;       // boot block is presented once valid
      end else if (any_taken) begin
        ip_q  <= taken_ip;
        ght_q <= {ght_q[`FE_GHT_W-2:0], 1'b1};
      end else begin
        ip_q <= seq_ip;
        if (cond_seen) begin
          ght_q <= {ght_q[`FE_GHT_W-2:0], 1'b0};
        end
      end
    end
  end

  assign ip  = ip_q;
  assign ght = ght_q;

  assign fetch.valid = valid_q;
  assign fetch.ip    = ip_q;
  assign fetch.ght   = ght_q;
  assign fetch.taken = any_taken;
  assign fetch.way   = any_taken ? sel_way : 1'b0;

endmodule

// File: verilog/target_buffer.sv
// two-way tagged branch target buffer
// combinational lookup on the fetch address, install from retire

`timescale 1ns/1ps
`include "frontend_macros.svh"

module target_buffer import frontend_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  ip_t           ip,
  input  retire_upd_t   upd,
  output tb_hit_t [1:0] hits
);

  localparam int IDX_W = $clog2(`FE_TB_SETS);

  typedef logic [IDX_W-1:0]                 set_idx_t;
  typedef logic [`FE_IP_W-1:`FE_TB_TAG_LO]  tag_t;

  tb_entry_t tb_q [`FE_TB_SETS][2];

  set_idx_t  rd_set;
  tag_t      rd_tag;
  set_idx_t  wr_set;
  tb_entry_t wr_entry;

  assign rd_set = ip[`FE_BLK_OFF_W +: IDX_W];
  assign rd_tag = ip[`FE_IP_W-1:`FE_TB_TAG_LO];

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      hits[w].hit    = tb_q[rd_set][w].valid && tb_q[rd_set][w].tag == rd_tag;
      hits[w].kind   = tb_q[rd_set][w].kind;
      hits[w].target = tb_q[rd_set][w].target;
    end
  end

  // install on every retired branch, mispredicted or not
  assign wr_set          = upd.src_ip[`FE_BLK_OFF_W +: IDX_W];
  assign wr_entry.valid  = 1'b1;
  assign wr_entry.tag    = upd.src_ip[`FE_IP_W-1:`FE_TB_TAG_LO];
  assign wr_entry.kind   = upd.kind;
  assign wr_entry.target = upd.target;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < `FE_TB_SETS; s++) begin
        for (int w = 0; w < 2; w++) begin
          tb_q[s][w].valid <= 1'b0;
        end
      end
    end else if (upd.valid) begin
      tb_q[wr_set][upd.way] <= wr_entry;
    end
  end

endmodule

// File: verilog/direction_predictor.sv
// direction predictor for conditional branches
// three history-indexed tables, one bit per way, XORed together
// mispredicted conditionals toggle the way bit in all three

`timescale 1ns/1ps
`include "frontend_macros.svh"

module direction_predictor import frontend_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  ip_t         ip,
  input  ght_t        ght,
  input  retire_upd_t upd,
  output logic [1:0]  pred_taken
);

  localparam int IDX_W      = `FE_PT_IDX_W;
  localparam int PT_ENTRIES = 1 << IDX_W;

  logic [2:0][1:0] tbl_bits;
  logic            upd_toggle;

  // block address bits with the low nbits of history folded in
  function automatic logic [IDX_W-1:0] pt_index(input ip_t a, input ght_t h,
                                                input int unsigned nbits);
    logic [IDX_W-1:0] idx;
    idx = a[`FE_BLK_OFF_W +: IDX_W];
    for (int i = 0; i < `FE_GHT_W; i++) begin
      if (i < nbits) begin
        idx[i % IDX_W] ^= h[i];
      end
    end
    return idx;
  endfunction

  assign upd_toggle = upd.valid && upd.mispredict && upd.kind == BR_COND;

  for (genvar t = 0; t < 3; t++) begin : g_table
    localparam int unsigned HB = (t == 0) ? `FE_PA_BITS :
                                 (t == 1) ? `FE_PB_BITS : `FE_PC_BITS;

    logic [1:0]       table_q [PT_ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign rd_idx      = pt_index(ip, ght, HB);
    assign wr_idx      = pt_index(upd.src_ip, upd.ght, HB);
    assign tbl_bits[t] = table_q[rd_idx];

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int e = 0; e < PT_ENTRIES; e++) begin
          table_q[e] <= '0;
        end
      end else if (upd_toggle) begin
        table_q[wr_idx][upd.way] <= ~table_q[wr_idx][upd.way];
      end
    end
  end

  assign pred_taken = tbl_bits[0] ^ tbl_bits[1] ^ tbl_bits[2]; // one bit per way

endmodule

// File: verilog/return_stack.sv
// circular return address stack
// push writes above the top, pop moves the pointer down

`timescale 1ns/1ps
`include "frontend_macros.svh"

module return_stack import frontend_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  logic pop,
  input  ip_t  push_addr,
  output ip_t  top_addr
);

  localparam int PTR_W = $clog2(`FE_RAS_DEPTH);

  ip_t              stack_q [`FE_RAS_DEPTH];
  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] ptr_up;

  assign ptr_up = ptr_q + 1'b1; // wraps so overflow loses the oldest entry

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= '0;
    end else if (push) begin
      ptr_q <= ptr_up;
    end else if (pop) begin
      ptr_q <= ptr_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      stack_q[ptr_up] <= push_addr;
    end
  end

  // stale data when empty
  assign top_addr = stack_q[ptr_q];

endmodule

// File: verilog/fetch_frontend.sv
// fetch front end top
// fetch pointer, target buffer, direction predictor and return stack

`timescale 1ns/1ps

module fetch_frontend import frontend_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  retire_upd_t upd,
  output fetch_out_t  fetch
);

  ip_t           ip;
  ght_t          ght;
  tb_hit_t [1:0] hits;
  logic    [1:0] pred_taken;
  ip_t           top_addr;
  logic          push;
  logic          pop;
  ip_t           push_addr;

  fetch_pointer u_pointer (
    .clk        (clk),
    .rst        (rst),
    .upd        (upd),
    .hits       (hits),
    .pred_taken (pred_taken),
    .top_addr   (top_addr),
    .ip         (ip),
    .ght        (ght),
    .push       (push),
    .pop        (pop),
    .push_addr  (push_addr),
    .fetch      (fetch)
  );

  target_buffer u_tb (
    .clk  (clk),
    .rst  (rst),
    .ip   (ip),
    .upd  (upd),
    .hits (hits)
  );

  direction_predictor u_pred (
    .clk        (clk),
    .rst        (rst),
    .ip         (ip),
    .ght        (ght),
    .upd        (upd),
    .pred_taken (pred_taken)
  );

  return_stack u_ras (
    .clk       (clk),
    .rst       (rst),
    .push      (push),
    .pop       (pop),
    .push_addr (push_addr),
    .top_addr  (top_addr)
  );

endmodule

// File: dv/tb_clock.sv
// testbench clock source, free running

`timescale 1ns/1ps

module tb_clock #(
  parameter real PERIOD = 10.0
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2.0) clk = ~clk;

endmodule

// File: dv/fetch_frontend_assertions.sv
// concurrent checks on the fetch front end top ports
// reset valid, block alignment, redirect, sequential advance, history shift

`timescale 1ns/1ps
`include "frontend_macros.svh"

module fetch_frontend_assertions import frontend_pkg::*; (
  input logic        clk,
  input logic        rst,
  input retire_upd_t upd,
  input fetch_out_t  fetch
);

  int   fail_count = 0;
  logic redirect;

  assign redirect = upd.valid && upd.mispredict;

  // valid stays low on the edge after a reset edge
  a_reset_valid: assert property (@(posedge clk) rst |=> !fetch.valid)
    else begin
      fail_count++;
      $error("fetch valid high right after reset");
    end

  a_block_align: assert property (@(posedge clk) disable iff (rst)
      fetch.valid |-> fetch.ip[`FE_BLK_OFF_W-1:0] == '0)
    else begin
      fail_count++;
      $error("fetch address not block aligned");
    end

  a_valid_hold: assert property (@(posedge clk) disable iff (rst)
      fetch.valid |=> fetch.valid)
    else begin
      fail_count++;
      $error("fetch valid dropped without reset");
    end

  a_redirect: assert property (@(posedge clk) disable iff (rst)
      redirect |=> fetch.ip == $past(upd.src_ip) && fetch.ght == $past(upd.ght))
    else begin
      fail_count++;
      $error("mispredict did not restart at the branch block");
    end

  // fall-through block with no redirect pending
  a_sequential: assert property (@(posedge clk) disable iff (rst)
      fetch.valid && !redirect && !fetch.taken |=>
      fetch.ip == $past(fetch.ip) + ip_t'(`FE_BLOCK_BYTES))
    else begin
      fail_count++;
      $error("fall-through address did not advance by one block");
    end

  a_taken_hist: assert property (@(posedge clk) disable iff (rst)
      fetch.valid && !redirect && fetch.taken |=>
      fetch.ght == {$past(fetch.ght[`FE_GHT_W-2:0]), 1'b1})
    else begin
      fail_count++;
      $error("taken block did not shift a one into history");
    end

endmodule

// File: dv/fetch_frontend_tb.sv
// fetch front end testbench top
// reset, fall-through, jump, mispredict replay, call/return, way priority
// LCG stimulus, watchdog, bound checker monitoring

`timescale 1ns/1ps
`include "frontend_macros.svh"

module fetch_frontend_tb import frontend_pkg::*; ();

  // cycles of each test phase from reset to the final drain
  localparam int TOTAL_CYCLES = 9 + 10 + 3 + 4 + 5 + 4 + 2;

  logic        clk;
  logic        rst;
  retire_upd_t upd;
  fetch_out_t  fetch;
  logic [31:0] seed = 32'hedc0;

  tb_clock #(.PERIOD(10.0)) u_clk (.clk(clk));

  fetch_frontend dut0 (.clk(clk), .rst(rst), .upd(upd), .fetch(fetch));

  bind fetch_frontend fetch_frontend_assertions u_chk (
    .clk(clk), .rst(rst), .upd(upd), .fetch(fetch)
  );

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  // block aligned address with a random tag in the given set
  function automatic ip_t pick_block(input int set);
    logic [63:0] raw;
    ip_t         a;
    raw = {lcg_next(), lcg_next()};
    a = raw[`FE_IP_W-1:0];
    a[9:4] = set[5:0];
    a[3:0] = 4'h0;
    return a;
  endfunction

  function automatic retire_upd_t make_upd(input logic mis, input branch_kind_e kind,
                                           input logic way, input ip_t src, input ip_t tgt,
                                           input ght_t g);
    retire_upd_t u;
    u.valid      = 1'b1;
    u.way        = way;
    u.kind       = kind;
    u.src_ip     = src;
    u.target     = tgt;
    u.taken      = 1'b1;
    u.ght        = g;
    u.mispredict = mis;
    return u;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (exp == act) else begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      $display("Test failures found");
      $fatal(1);
    end
  endtask

  // one cycle strobe between two falling edges
  task automatic send_upd(input retire_upd_t u);
    upd = u;
    @(negedge clk);
    upd = '0;
  endtask

  always @(negedge clk) begin
    if (dut0.u_chk.fail_count != 0) begin
      $display("Error: a port assertion on the fetch front end failed");
      $display("Test failures found");
      $fatal(1);
    end
  end

  initial begin
    #(TOTAL_CYCLES * 10 * 2);
    $display("Error: run did not finish in time");
    $display("Test failures found");
    $fatal(1);
  end

  initial begin
    ip_t  a, t, b, u, c, r, d, e0, e1, exp_ip;
    ght_t g;
    rst = 1'b1;
    upd = '0;
    @(posedge clk); // first reset edge
    repeat (8) begin
      @(negedge clk);
      check("reset_valid", 0, fetch.valid);
    end
    rst = 1'b0;
    check("first_cycle_ip", `FE_RESET_IP, fetch.ip);
    check("first_cycle_ght", 0, fetch.ght);
    @(negedge clk);
    check("boot_valid", 1, fetch.valid);
    check("boot_ip", `FE_RESET_IP, fetch.ip);
    check("boot_ght", 0, fetch.ght);
    exp_ip = `FE_RESET_IP;
    for (int i = 0; i < 10; i++) begin
      exp_ip = exp_ip + ip_t'(`FE_BLOCK_BYTES);
      @(negedge clk);
      check("fall_through_ip", exp_ip, fetch.ip);
      check("fall_through_ght", 0, fetch.ght);
    end

    // jump install and a replay into it
    a = pick_block(1);
    t = pick_block(2);
    g = ght_t'(lcg_next());
    send_upd(make_upd(1'b0, BR_JUMP, 1'b0, a, t, '0));
    send_upd(make_upd(1'b1, BR_JUMP, 1'b0, a, t, g));
    check("jump_replay_ip", a, fetch.ip);
    @(negedge clk);
    check("jump_target", t, fetch.ip);
    check("jump_ght", {g[`FE_GHT_W-2:0], 1'b1}, fetch.ght);

    // conditional mispredict flips the way prediction
    b = pick_block(3);
    u = pick_block(4);
    g = ght_t'(lcg_next());
    send_upd(make_upd(1'b1, BR_COND, 1'b1, b, u, g));
    check("cond_replay_ip", b, fetch.ip);
    check("cond_replay_ght", g, fetch.ght);
    check("cond_taken", 1, fetch.taken);
    check("cond_way", 1, fetch.way);
    @(negedge clk);
    check("cond_target", u, fetch.ip);
    send_upd(make_upd(1'b1, BR_COND, 1'b1, b, u, g));
    check("cond_flip_ip", b, fetch.ip);
    check("cond_flip_taken", 0, fetch.taken);
    @(negedge clk);
    check("cond_flip_next", b + 16, fetch.ip);
    check("cond_flip_ght", {g[`FE_GHT_W-2:0], 1'b0}, fetch.ght);

    // call then return
    c = pick_block(8);
    r = pick_block(10);
    send_upd(make_upd(1'b0, BR_CALL, 1'b0, c, r, '0));
    send_upd(make_upd(1'b0, BR_RET, 1'b0, r, '0, '0));
    send_upd(make_upd(1'b1, BR_CALL, 1'b0, c, r, ght_t'(lcg_next())));
    check("call_replay_ip", c, fetch.ip);
    @(negedge clk);
    check("call_target", r, fetch.ip);
    @(negedge clk);
    check("return_target", c + 16, fetch.ip);

    // both ways taken so way 0 wins
    d  = pick_block(12);
    e0 = pick_block(13);
    e1 = pick_block(14);
    send_upd(make_upd(1'b0, BR_JUMP, 1'b0, d, e0, '0));
    send_upd(make_upd(1'b0, BR_JUMP, 1'b1, d, e1, '0));
    send_upd(make_upd(1'b1, BR_JUMP, 1'b0, d, e0, ght_t'(lcg_next())));
    check("prio_replay_ip", d, fetch.ip);
    check("prio_taken", 1, fetch.taken);
    check("prio_way", 0, fetch.way);
    @(negedge clk);
    check("prio_target", e0, fetch.ip);

    repeat (2) @(negedge clk);
    if (dut0.u_chk.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("Test failures found");
      $fatal(1);
    end
  end

endmodule

// File: fetch_frontend.f
+incdir+include
verilog/frontend_pkg.sv
verilog/fetch_pointer.sv
verilog/target_buffer.sv
verilog/direction_predictor.sv
verilog/return_stack.sv
verilog/fetch_frontend.sv
dv/tb_clock.sv
dv/fetch_frontend_assertions.sv
dv/fetch_frontend_tb.sv

// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - include
    files:
      - verilog/frontend_pkg.sv
      - verilog/fetch_pointer.sv
      - verilog/target_buffer.sv
      - verilog/direction_predictor.sv
      - verilog/return_stack.sv
      - verilog/fetch_frontend.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/tb_clock.sv
      - dv/fetch_frontend_assertions.sv
      - dv/fetch_frontend_tb.sv
